//--- hw/wb_pkg.sv
package wb_pkg;

    localparam int NUM_SLOTS      = 4;
    localparam int SLOT_W         = $clog2(NUM_SLOTS);
    localparam int DATA_W         = 64;
    localparam int ADDR_W         = 32;
    localparam int GPR_W          = 32;
    localparam int SEG_W          = 16;
    localparam int NUM_REGS       = 8;
    localparam int IDX_W          = $clog2(NUM_REGS);
    localparam int SIZE_W         = 2;
    localparam int ALIAS_W        = 6;
    localparam int IE_TYPE_W      = 4;
    localparam int CS_IDX         = 1;   // segment file slot of CS
    localparam int WBAQ_DEPTH     = 4;   // power of two, pointers wrap
    localparam int WBAQ_PTR_W     = $clog2(WBAQ_DEPTH);
    localparam int LINE_BYTES_LOG = 4;
    localparam int FIP_SWAP_BIT   = 5;   // even/odd line swap

    localparam logic [SIZE_W-1:0] FAR_SIZE = 2'd3;

    typedef logic [GPR_W-1:0] gpr_t;
    typedef logic [SEG_W-1:0] seg_t;

endpackage

//--- hw/wb_latch.sv
`timescale 1ns/1ps

module wb_latch (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          ex_valid,
    input  logic [wb_pkg::ADDR_W-1:0]     eip, latched_eip,
    input  logic [wb_pkg::DATA_W-1:0]     res [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::ADDR_W-1:0]     dest [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::NUM_SLOTS-1:0]  is_reg, is_seg, is_mem, wb,
    input  logic [wb_pkg::SIZE_W-1:0]     size,
    input  logic                          br_valid, br_taken, br_correct,
    input  logic [wb_pkg::ADDR_W-1:0]     br_fip, br_fip_p1,
    input  logic [wb_pkg::ALIAS_W-1:0]    bp_alias,
    input  logic                          far_xfer,
    input  logic                          ie,
    input  logic [wb_pkg::IE_TYPE_W-1:0]  ie_type,
    output logic                          q_valid,
    output logic [wb_pkg::ADDR_W-1:0]     q_eip, q_latched_eip,
    output logic [wb_pkg::DATA_W-1:0]     q_res [wb_pkg::NUM_SLOTS],
    output logic [wb_pkg::ADDR_W-1:0]     q_dest [wb_pkg::NUM_SLOTS],
    output logic [wb_pkg::NUM_SLOTS-1:0]  q_is_reg, q_is_seg, q_is_mem, q_wb,
    output logic [wb_pkg::SIZE_W-1:0]     q_size,
    output logic                          q_br_valid, q_br_taken, q_br_correct,
    output logic [wb_pkg::ADDR_W-1:0]     q_br_fip, q_br_fip_p1,
    output logic [wb_pkg::ALIAS_W-1:0]    q_bp_alias,
    output logic                          q_far_xfer,
    output logic                          q_ie,
    output logic [wb_pkg::IE_TYPE_W-1:0]  q_ie_type
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (!stall) begin
            q_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin          // hold whole instruction on stall
            q_eip         <= eip;
            q_latched_eip <= latched_eip;
            q_res         <= res;
            q_dest        <= dest;
            q_is_reg      <= is_reg;
            q_is_seg      <= is_seg;
            q_is_mem      <= is_mem;
            q_wb          <= wb;
            q_size        <= size;
            q_br_valid    <= br_valid;
            q_br_taken    <= br_taken;
            q_br_correct  <= br_correct;
            q_br_fip      <= br_fip;
            q_br_fip_p1   <= br_fip_p1;
            q_bp_alias    <= bp_alias;
            q_far_xfer    <= far_xfer;
            q_ie          <= ie;
            q_ie_type     <= ie_type;
        end
    end

    // a stalled store must still be there next cycle
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n) stall |=> q_valid)
        else $error("wb_latch: q_valid dropped while stalled");

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                          q_valid,
    input  logic [wb_pkg::ADDR_W-1:0]     q_eip, q_latched_eip,
    input  logic [wb_pkg::DATA_W-1:0]     q_res [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::ADDR_W-1:0]     q_dest [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::NUM_SLOTS-1:0]  q_is_reg, q_is_seg, q_is_mem, q_wb,
    input  logic [wb_pkg::SIZE_W-1:0]     q_size,
    input  logic                          q_br_valid, q_br_taken, q_br_correct,
    input  logic [wb_pkg::ADDR_W-1:0]     q_br_fip, q_br_fip_p1,
    input  logic [wb_pkg::ALIAS_W-1:0]    q_bp_alias,
    input  logic                          q_far_xfer,
    input  logic                          q_ie,
    input  logic [wb_pkg::IE_TYPE_W-1:0]  q_ie_type,
    input  logic                          interrupt,
    input  logic                          full,
    output logic                          valid_out,
    output logic                          stall,
    output logic [wb_pkg::NUM_SLOTS-1:0]  reg_we,
    output logic [wb_pkg::IDX_W-1:0]      reg_idx [wb_pkg::NUM_SLOTS],
    output wb_pkg::gpr_t                  reg_wdata [wb_pkg::NUM_SLOTS],
    output logic [wb_pkg::NUM_SLOTS-1:0]  seg_we,
    output logic [wb_pkg::IDX_W-1:0]      seg_idx [wb_pkg::NUM_SLOTS],
    output wb_pkg::seg_t                  seg_wdata [wb_pkg::NUM_SLOTS],
    output logic                          push,
    output logic [wb_pkg::ADDR_W-1:0]     push_addr,
    output logic [wb_pkg::DATA_W-1:0]     push_data,
    output logic [wb_pkg::SIZE_W-1:0]     push_size,
    output logic [wb_pkg::ADDR_W-1:0]     new_eip, new_fip_e, new_fip_o,
    output logic                          is_resteer,
    output logic                          br_valid_out, br_taken_out,
    output logic [wb_pkg::ALIAS_W-1:0]    bp_alias_out,
    output logic [wb_pkg::ADDR_W-1:0]     latched_eip_out,
    output logic                          final_ie,
    output logic [wb_pkg::IE_TYPE_W-1:0]  final_ie_type
);
    import wb_pkg::*;

    logic              any_mem;
    logic [SLOT_W-1:0] st_sel;
    logic [ADDR_W-1:0] target;
    logic [ADDR_W-1:0] fip_line, fip_p1_line;

    assign any_mem   = |q_is_mem;
    assign stall     = full & q_valid & any_mem;
    assign valid_out = q_valid & ~stall;

    assign reg_we = {NUM_SLOTS{valid_out}} & q_is_reg & q_wb;
    assign seg_we = {NUM_SLOTS{valid_out}} & q_is_seg & q_wb;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            reg_idx[i]   = q_dest[i][IDX_W-1:0];
            reg_wdata[i] = q_res[i][GPR_W-1:0];
            seg_idx[i]   = q_dest[i][IDX_W-1:0];
            seg_wdata[i] = q_res[i][SEG_W-1:0];
        end
        if (q_far_xfer) begin                          // far jump reloads CS
            seg_idx[0]   = IDX_W'(CS_IDX);
            seg_wdata[0] = q_res[0][ADDR_W +: SEG_W];  // selector above the offset
        end
    end

    // lowest store slot wins
    always_comb begin
        st_sel = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (q_is_mem[i]) begin
                st_sel = SLOT_W'(i);
            end
        end
    end

    assign push      = valid_out & any_mem;
    assign push_addr = q_dest[st_sel];
    assign push_data = q_res[st_sel];
    assign push_size = q_far_xfer ? FAR_SIZE : q_size;

    assign target      = q_far_xfer ? q_res[0][ADDR_W-1:0] : q_br_fip;
    assign new_eip     = q_br_taken ? target : q_eip;
    assign fip_line    = {q_br_fip[ADDR_W-1:LINE_BYTES_LOG], {LINE_BYTES_LOG{1'b0}}};
    assign fip_p1_line = {q_br_fip_p1[ADDR_W-1:LINE_BYTES_LOG], {LINE_BYTES_LOG{1'b0}}};
    assign new_fip_e   = q_br_fip[FIP_SWAP_BIT] ? fip_p1_line : fip_line;
    assign new_fip_o   = q_br_fip[FIP_SWAP_BIT] ? fip_line : fip_p1_line;
    assign is_resteer  = valid_out & q_br_valid & ~q_br_correct;

    assign br_valid_out    = q_br_valid;
    assign br_taken_out    = q_br_taken;
    assign bp_alias_out    = q_bp_alias;
    assign latched_eip_out = q_latched_eip;

    assign final_ie      = (q_valid & q_ie) | interrupt;  // bubbles raise nothing
    assign final_ie_type = {interrupt, q_ie_type[2:0]};

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter type entry_t = wb_pkg::gpr_t
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [wb_pkg::NUM_SLOTS-1:0]  we,
    input  logic [wb_pkg::IDX_W-1:0]      widx [wb_pkg::NUM_SLOTS],
    input  entry_t                        wdata [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::IDX_W-1:0]      raddr,
    output entry_t                        rdata
);
    import wb_pkg::*;

    entry_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin  // higher slot lands last
                if (we[i]) begin
                    regs[widx[i]] <= wdata[i];
                end
            end
        end
    end

    assign rdata = regs[raddr];  // operand read for decode

endmodule

//--- hw/wbaq.sv
`timescale 1ns/1ps

module wbaq (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic                       mem_ack,
    input  logic [wb_pkg::ADDR_W-1:0]  push_addr,
    input  logic [wb_pkg::DATA_W-1:0]  push_data,
    input  logic [wb_pkg::SIZE_W-1:0]  push_size,
    output logic                       full,
    output logic                       mem_req,
    output logic [wb_pkg::ADDR_W-1:0]  mem_addr,
    output logic [wb_pkg::DATA_W-1:0]  mem_data,
    output logic [wb_pkg::SIZE_W-1:0]  mem_size
);
    import wb_pkg::*;

    logic [ADDR_W-1:0]     addr_q [WBAQ_DEPTH];
    logic [DATA_W-1:0]     data_q [WBAQ_DEPTH];
    logic [SIZE_W-1:0]     size_q [WBAQ_DEPTH];
    logic [WBAQ_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [WBAQ_PTR_W:0]   count;
    logic                  pop;

    assign mem_req = (count != '0);
    assign full    = (count == (WBAQ_PTR_W + 1)'(WBAQ_DEPTH));
    assign pop     = mem_ack & mem_req;  // stray ack on empty queue dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= push_addr;
            data_q[wr_ptr] <= push_data;
            size_q[wr_ptr] <= push_size;
        end
    end

    assign mem_addr = addr_q[rd_ptr];
    assign mem_data = data_q[rd_ptr];
    assign mem_size = size_q[rd_ptr];

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("wbaq: push into full queue");

    a_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n) mem_ack |-> mem_req)
        else $error("wbaq: mem_ack without mem_req");

endmodule

//--- hw/wb_top.sv
`timescale 1ns/1ps

module wb_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    input  logic [wb_pkg::ADDR_W-1:0]     eip, latched_eip,
    input  logic [wb_pkg::DATA_W-1:0]     res [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::ADDR_W-1:0]     dest [wb_pkg::NUM_SLOTS],
    input  logic [wb_pkg::NUM_SLOTS-1:0]  is_reg, is_seg, is_mem, wb,
    input  logic [wb_pkg::SIZE_W-1:0]     size,
    input  logic                          br_valid, br_taken, br_correct,
    input  logic [wb_pkg::ADDR_W-1:0]     br_fip, br_fip_p1,
    input  logic [wb_pkg::ALIAS_W-1:0]    bp_alias,
    input  logic                          far_xfer,
    input  logic                          ie,
    input  logic [wb_pkg::IE_TYPE_W-1:0]  ie_type,
    input  logic                          interrupt,
    input  logic                          mem_ack,
    input  logic [wb_pkg::IDX_W-1:0]      gpr_raddr, seg_raddr,
    output wb_pkg::gpr_t                  gpr_rdata,
    output wb_pkg::seg_t                  seg_rdata,
    output logic                          mem_req,
    output logic [wb_pkg::ADDR_W-1:0]     mem_addr,
    output logic [wb_pkg::DATA_W-1:0]     mem_data,
    output logic [wb_pkg::SIZE_W-1:0]     mem_size,
    output logic                          stall,
    output logic                          valid_out,
    output logic [wb_pkg::ADDR_W-1:0]     new_eip, new_fip_e, new_fip_o,
    output logic                          is_resteer,
    output logic                          br_valid_out, br_taken_out,
    output logic [wb_pkg::ALIAS_W-1:0]    bp_alias_out,
    output logic [wb_pkg::ADDR_W-1:0]     latched_eip_out,
    output logic                          final_ie,
    output logic [wb_pkg::IE_TYPE_W-1:0]  final_ie_type
);
    import wb_pkg::*;

    logic                 q_valid;
    logic [ADDR_W-1:0]    q_eip, q_latched_eip;
    logic [DATA_W-1:0]    q_res [NUM_SLOTS];
    logic [ADDR_W-1:0]    q_dest [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] q_is_reg, q_is_seg, q_is_mem, q_wb;
    logic [SIZE_W-1:0]    q_size;
    logic                 q_br_valid, q_br_taken, q_br_correct;
    logic [ADDR_W-1:0]    q_br_fip, q_br_fip_p1;
    logic [ALIAS_W-1:0]   q_bp_alias;
    logic                 q_far_xfer;
    logic                 q_ie;
    logic [IE_TYPE_W-1:0] q_ie_type;

    logic [NUM_SLOTS-1:0] reg_we, seg_we;
    logic [IDX_W-1:0]     reg_idx [NUM_SLOTS];
    logic [IDX_W-1:0]     seg_idx [NUM_SLOTS];
    gpr_t                 reg_wdata [NUM_SLOTS];
    seg_t                 seg_wdata [NUM_SLOTS];

    logic                 push, full;
    logic [ADDR_W-1:0]    push_addr;
    logic [DATA_W-1:0]    push_data;
    logic [SIZE_W-1:0]    push_size;

    wb_latch i_wb_latch (.*);  // names line up with execute ports

    wb_stage i_wb_stage (.*);

    reg_file #(.entry_t(gpr_t)) i_gpr_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (reg_we),
        .widx  (reg_idx),
        .wdata (reg_wdata),
        .raddr (gpr_raddr),
        .rdata (gpr_rdata)
    );

    reg_file #(.entry_t(seg_t)) i_seg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (seg_we),
        .widx  (seg_idx),
        .wdata (seg_wdata),
        .raddr (seg_raddr),
        .rdata (seg_rdata)
    );

    wbaq i_wbaq (.*);

endmodule

//--- dv/tb_clk.sv
`timescale 1ns/1ps

module tb_clk (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;
    import wb_pkg::*;

    localparam int WATCHDOG_CYCLES = 2000;  // tests need roughly 300 cycles

    logic                 clk, rst_n;
    logic                 ex_valid;
    logic [ADDR_W-1:0]    eip, latched_eip;
    logic [DATA_W-1:0]    res [NUM_SLOTS];
    logic [ADDR_W-1:0]    dest [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] is_reg, is_seg, is_mem, wb;
    logic [SIZE_W-1:0]    size;
    logic                 br_valid, br_taken, br_correct;
    logic [ADDR_W-1:0]    br_fip, br_fip_p1;
    logic [ALIAS_W-1:0]   bp_alias;
    logic                 far_xfer, ie, interrupt, mem_ack;
    logic [IE_TYPE_W-1:0] ie_type;
    logic [IDX_W-1:0]     gpr_raddr, seg_raddr;
    gpr_t                 gpr_rdata;
    seg_t                 seg_rdata;
    logic                 mem_req, stall, valid_out, is_resteer;
    logic [ADDR_W-1:0]    mem_addr, new_eip, new_fip_e, new_fip_o, latched_eip_out;
    logic [DATA_W-1:0]    mem_data;
    logic [SIZE_W-1:0]    mem_size;
    logic                 br_valid_out, br_taken_out, final_ie;
    logic [ALIAS_W-1:0]   bp_alias_out;
    logic [IE_TYPE_W-1:0] final_ie_type;

    gpr_t              gpr_model [NUM_REGS];
    seg_t              seg_model [NUM_REGS];
    logic [ADDR_W-1:0] st_addr_q [$];  // expected stores in push order
    logic [DATA_W-1:0] st_data_q [$];
    logic [SIZE_W-1:0] st_size_q [$];
    int                err_cnt;
    integer            seed;

    tb_clk i_tb_clk (.clk(clk), .rst_n(rst_n));

    wb_top i_wb_top (.*);

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("ERR %s exp=%h act=%h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic clear_inputs();
        ex_valid    <= 1'b0;
        eip         <= '0;
        latched_eip <= '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            res[i]  <= '0;
            dest[i] <= '0;
        end
        is_reg     <= '0;
        is_seg     <= '0;
        is_mem     <= '0;
        wb         <= '0;
        size       <= '0;
        br_valid   <= 1'b0;
        br_taken   <= 1'b0;
        br_correct <= 1'b0;
        br_fip     <= '0;
        br_fip_p1  <= '0;
        bp_alias   <= '0;
        far_xfer   <= 1'b0;
        ie         <= 1'b0;
        ie_type    <= '0;
    endtask

    task automatic fill_random_slots(input logic [ADDR_W-1:0] dest_mask);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            res[i]  <= {$random(seed), $random(seed)};
            dest[i] <= ADDR_W'($random(seed)) & dest_mask;
        end
        size <= SIZE_W'($random(seed));
    endtask

    // expected effect of the instruction sitting on the inputs
    task automatic update_model();
        int st;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (is_reg[i] && wb[i]) begin
                gpr_model[dest[i][2:0]] = res[i][31:0];
            end
            if (is_seg[i] && wb[i]) begin
                if (i == 0 && far_xfer) begin
                    seg_model[CS_IDX] = res[0][47:32];
                end else begin
                    seg_model[dest[i][2:0]] = res[i][15:0];
                end
            end
        end
        st = -1;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (is_mem[i]) begin
                st = i;  // lowest store slot
            end
        end
        if (st >= 0) begin
            st_addr_q.push_back(dest[st]);
            st_data_q.push_back(res[st]);
            st_size_q.push_back(far_xfer ? 2'd3 : size);
        end
    endtask

    task automatic issue();
        ex_valid <= 1'b1;
        do begin
            @(negedge clk);
        end while (stall);  // execute holds while stalled
        update_model();
        @(posedge clk);     // captured here
        clear_inputs();
    endtask

    task automatic check_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(posedge clk);
            gpr_raddr <= IDX_W'(r);
            seg_raddr <= IDX_W'(r);
            @(negedge clk);
            compare($sformatf("gpr_rdata[%0d]", r), 64'(gpr_model[r]), 64'(gpr_rdata));
            compare($sformatf("seg_rdata[%0d]", r), 64'(seg_model[r]), 64'(seg_rdata));
        end
    endtask

    task automatic pop_store();
        @(negedge clk);
        if (!mem_req) begin
            $display("mem_req is low but %0d stores are still expected", st_addr_q.size());
            err_cnt++;
            st_addr_q.delete();
            st_data_q.delete();
            st_size_q.delete();
            return;
        end
        compare("mem_addr", 64'(st_addr_q[0]), 64'(mem_addr));
        compare("mem_data", st_data_q[0], mem_data);
        compare("mem_size", 64'(st_size_q[0]), 64'(mem_size));
        void'(st_addr_q.pop_front());
        void'(st_data_q.pop_front());
        void'(st_size_q.pop_front());
        @(posedge clk);
        mem_ack <= 1'b1;
        @(posedge clk);
        mem_ack <= 1'b0;
    endtask

    task automatic drain_stores();
        @(posedge clk);  // last push lands
        while (st_addr_q.size() > 0) begin
            pop_store();
        end
        @(negedge clk);
        if (mem_req) begin
            $display("mem_req stays high after all expected stores were taken");
            err_cnt++;
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare("mem_req", 64'(1'b0), 64'(mem_req));
        compare("stall", 64'(1'b0), 64'(stall));
        compare("valid_out", 64'(1'b0), 64'(valid_out));
        compare("is_resteer", 64'(1'b0), 64'(is_resteer));
        compare("final_ie", 64'(1'b0), 64'(final_ie));
        check_regs();
    endtask

    task automatic test_reg_writes();
        for (int n = 0; n < 6; n++) begin
            @(posedge clk);
            fill_random_slots((n % 2 == 1) ? 32'h7 : 32'h3);  // narrow range collides
            is_reg <= NUM_SLOTS'($random(seed));
            is_seg <= NUM_SLOTS'($random(seed));
            wb     <= NUM_SLOTS'($random(seed));
            if (n == 0) begin
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    dest[i] <= 32'd2;  // all slots on one entry
                end
                is_reg <= '1;
                is_seg <= '1;
                wb     <= '1;
            end
            issue();
            check_regs();
        end
    endtask

    task automatic test_store_queue();
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            fill_random_slots('1);
            is_mem <= NUM_SLOTS'($random(seed)) | NUM_SLOTS'(8);
            issue();
            if (n == 0) begin
                @(negedge clk);
                compare("mem_req", 64'(1'b0), 64'(mem_req));  // push not landed yet
            end
        end
        drain_stores();
    endtask

    task automatic test_back_pressure();
        gpr_t old_val;
        for (int n = 0; n < WBAQ_DEPTH; n++) begin
            @(posedge clk);
            fill_random_slots('1);
            is_mem <= NUM_SLOTS'(1) << (n % NUM_SLOTS);
            issue();
        end
        old_val = gpr_model[5];
        @(posedge clk);
        fill_random_slots('1);
        dest[1]   <= 32'd5;
        is_mem    <= 4'b0001;
        is_reg    <= 4'b0010;
        wb        <= 4'b0010;
        gpr_raddr <= 3'd5;
        issue();
        repeat (3) begin
            @(negedge clk);
            compare("stall", 64'(1'b1), 64'(stall));
            compare("valid_out", 64'(1'b0), 64'(valid_out));
            compare("gpr_rdata[5]", 64'(old_val), 64'(gpr_rdata));
        end
        pop_store();
        @(negedge clk);
        compare("stall", 64'(1'b0), 64'(stall));
        compare("valid_out", 64'(1'b1), 64'(valid_out));
        compare("gpr_rdata[5]", 64'(old_val), 64'(gpr_rdata));
        @(negedge clk);
        compare("gpr_rdata[5]", 64'(gpr_model[5]), 64'(gpr_rdata));
        drain_stores();
    endtask

    task automatic redirect_case(input logic taken, input logic correct,
                                 input logic [ADDR_W-1:0] fip, input logic far);
        logic [DATA_W-1:0]  r0;
        logic [ADDR_W-1:0]  e, le, fip_p1, exp_tgt, exp_eip, line_e, line_o, tmp;
        logic [ALIAS_W-1:0] alias_val;
        r0        = {$random(seed), $random(seed)};
        e         = ADDR_W'($random(seed));
        le        = ADDR_W'($random(seed));
        alias_val = ALIAS_W'($random(seed));
        fip_p1    = fip + 32'h10;
        exp_tgt   = far ? r0[31:0] : fip;
        exp_eip   = taken ? exp_tgt : e;
        line_e    = {fip[31:4], 4'h0};
        line_o    = {fip_p1[31:4], 4'h0};
        if (fip[5]) begin
            tmp    = line_e;
            line_e = line_o;
            line_o = tmp;
        end
        @(posedge clk);
        fill_random_slots('1);
        res[0]      <= r0;
        eip         <= e;
        latched_eip <= le;
        br_valid    <= 1'b1;
        br_taken    <= taken;
        br_correct  <= correct;
        br_fip      <= fip;
        br_fip_p1   <= fip_p1;
        bp_alias    <= alias_val;
        far_xfer    <= far;
        if (far) begin
            is_seg <= 4'b0001;  // CS load from slot 0
            wb     <= 4'b0001;
            is_mem <= 4'b0010;
        end
        issue();
        @(negedge clk);
        compare("new_eip", 64'(exp_eip), 64'(new_eip));
        compare("new_fip_e", 64'(line_e), 64'(new_fip_e));
        compare("new_fip_o", 64'(line_o), 64'(new_fip_o));
        compare("is_resteer", 64'(!correct), 64'(is_resteer));
        compare("bp_alias_out", 64'(alias_val), 64'(bp_alias_out));
        compare("br_valid_out", 64'(1'b1), 64'(br_valid_out));
        compare("br_taken_out", 64'(taken), 64'(br_taken_out));
        compare("latched_eip_out", 64'(le), 64'(latched_eip_out));
        if (far) begin
            drain_stores();
        end
    endtask

    task automatic test_exceptions();
        logic [IE_TYPE_W-1:0] t;
        for (int c = 0; c < 4; c++) begin
            t = IE_TYPE_W'($random(seed));
            @(posedge clk);
            ie        <= c[0];
            interrupt <= c[1];
            ie_type   <= t;
            issue();
            @(negedge clk);
            compare("final_ie", 64'(c[0] | c[1]), 64'(final_ie));
            compare("final_ie_type", 64'({c[1], t[2:0]}), 64'(final_ie_type));
            @(posedge clk);
            interrupt <= 1'b0;
        end
    endtask

    initial begin
        seed    = 79864;
        err_cnt = 0;
        clear_inputs();
        interrupt <= 1'b0;
        mem_ack   <= 1'b0;
        gpr_raddr <= '0;
        seg_raddr <= '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            gpr_model[r] = '0;
            seg_model[r] = '0;
        end
        wait (rst_n === 1'b1);
        test_reset();
        test_reg_writes();
        test_store_queue();
        test_back_pressure();
        redirect_case(1'b1, 1'b1, 32'h1000_0104, 1'b0);  // taken, bit 5 clear
        redirect_case(1'b0, 1'b1, 32'h2000_0028, 1'b0);  // not taken, bit 5 set
        redirect_case(1'b1, 1'b0, 32'h3000_00ec, 1'b0);  // mispredicted
        redirect_case(1'b0, 1'b0, 32'h4000_0047, 1'b0);
        redirect_case(1'b1, 1'b1, 32'h5000_0010, 1'b1);  // far jump
        check_regs();
        test_exceptions();
        $display("tests done, error count %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

//--- files.f
hw/wb_pkg.sv
hw/wb_latch.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/wbaq.sv
hw/wb_top.sv
dv/tb_clk.sv
dv/wb_tb.sv

//--- Makefile
TOP = wb_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f hw/*.sv dv/*.sv
	verilator --binary --timing --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
